// ==== flashCtrlPkg.sv ====
// Widths, flash CSR words and sequencer states shared by the flash update controller RTL
package flashCtrlPkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int hostAddrW  = 7;                         // Host 16-bit word address
  localparam int hostDataW  = 16;                        // Host word
  localparam int ramAddrW   = 6;                         // Holding RAM index, also op length
  localparam int flashAddrW = 18;                        // Flash word address
  localparam int flashDataW = 32;                        // Flash word and CSR word

  ////////////////////
  // CSR control words
  ////////////////////
  // Bits 26:23 are the per-sector protect bits, 22:20 select the sector to erase
  localparam logic [flashDataW-1:0] csrProtectNone = 32'hFFFF_FFFF; // Protect everything
  localparam logic [flashDataW-1:0] csrUnprotCfm1  = 32'hFBFF_FFFF; // CFM1 writable
  localparam logic [flashDataW-1:0] csrEraseCfm1   = 32'hFBCF_FFFF; // CFM1 writable, erase CFM1
  localparam logic [flashDataW-1:0] csrUnprotCfm2  = 32'hFDFF_FFFF; // CFM2 writable
  localparam logic [flashDataW-1:0] csrEraseCfm2   = 32'hFDBF_FFFF; // CFM2 writable, erase CFM2
  localparam logic [flashDataW-1:0] csrUnprotBoth  = 32'hF9FF_FFFF; // Both writable, for data writes

  ////////////////////
  // Status word fields
  ////////////////////
  localparam int statusBusyLsb    = 0;                   // 2-bit busy field, zero when idle
  localparam int statusWriteOkBit = 3;                   // Last write succeeded
  localparam int statusEraseOkBit = 4;                   // Last erase succeeded

  ////////////////////
  // Sequencer states
  ////////////////////
  typedef enum logic [5:0] {
    // Status monitor loop
    monSet, monLat, monStr, monVal,
    // Two-sector erase
    erPrep,
    er1ClrProt, er1SelErase, er1BusySet, er1BusyLat, er1BusyStr,
    er1WaitBusy, er1WaitIdle, er1Check, er1Protect,
    er2ClrProt, er2SelErase, er2BusySet, er2BusyLat, er2BusyStr,
    er2WaitBusy, er2WaitIdle, er2Check, er2Protect,
    // Multi-word write
    wrPrep, wrUnprot, wrLoad, wrCommit, wrReqHigh, wrReqLow,
    wrIdleSet, wrIdleStr, wrWaitIdle, wrCheck, wrProtect
  } seqState;

endpackage

// ==== flashStageRam.sv ====
// Holding RAM that pairs host 16-bit words into 32-bit flash words; read by the write cursor
`timescale 1ns/1ps

module flashStageRam
  import flashCtrlPkg::*;
(
  input  logic                  Clock,
  input  logic                  arstN,
  input  logic [hostAddrW-1:0]  FlashMemWrAddress,    // Host word address, bit 0 picks the half
  input  logic [hostDataW-1:0]  FlashMemWrData,       // Host word
  input  logic                  FlashMemWrEn,         // Host write strobe
  input  logic [ramAddrW-1:0]   ramRdAddr,            // Index from the write cursor
  output logic [flashDataW-1:0] ramRdData             // Paired word, one cycle after ramRdAddr
);

  logic [hostDataW-1:0]  upperHalf;                   // Last host word, becomes the MSW
  logic                  ramWe;                       // Write on the odd half only
  logic [flashDataW-1:0] ram [0:(1 << ramAddrW)-1];   // 64 paired flash words

  // Every host word is kept so the next odd word can join it
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
      upperHalf <= '0;
    else if (FlashMemWrEn)
      upperHalf <= FlashMemWrData;
  end

  assign ramWe = FlashMemWrEn & FlashMemWrAddress[0]; // Second word of a pair completes it

  // Upper address bits select the entry
  always_ff @(posedge Clock)
  begin
    if (ramWe)
      ram[FlashMemWrAddress[hostAddrW-1:1]] <= {upperHalf, FlashMemWrData};
  end

  // Synchronous read port
  always_ff @(posedge Clock)
  begin
    ramRdData <= ram[ramRdAddr];
  end

endmodule

// ==== flashWriteCursor.sv ====
// Tracks the RAM index, flash address and remaining words for the sequencer's write loop
`timescale 1ns/1ps

module flashWriteCursor
  import flashCtrlPkg::*;
(
  input  logic                  Clock,
  input  logic                  arstN,
  input  logic                  writePrep,            // Start of a write operation
  input  logic                  writeDone,            // One word committed and checked
  input  logic [flashAddrW-1:0] FlashOpAddr,          // First flash word address
  input  logic [ramAddrW-1:0]   FlashOpLen,           // Words to write, 0 acts as 1
  output logic [ramAddrW-1:0]   ramRdAddr,            // Holding RAM read index
  output logic [flashAddrW-1:0] flashWrAddr,          // Flash address of the current word
  output logic [ramAddrW-1:0]   wordsLeft             // Remaining count, sequencer loops while > 1
);

  // RAM index always starts at entry 0
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
      ramRdAddr <= '0;
    else if (writePrep)
      ramRdAddr <= '0;
    else if (writeDone)
      ramRdAddr <= ramRdAddr + 1'b1;                  // Next paired word
  end

  // Flash address follows the RAM index
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
      flashWrAddr <= '0;
    else if (writePrep)
      flashWrAddr <= FlashOpAddr;                     // Load start address
    else if (writeDone)
      flashWrAddr <= flashWrAddr + 1'b1;
  end

  // Count down, holding at zero
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
      wordsLeft <= '0;
    else if (writePrep)
      wordsLeft <= FlashOpLen;
    else if (writeDone && (wordsLeft != '0))
      wordsLeft <= wordsLeft - 1'b1;
  end

endmodule

// ==== flashSequencer.sv ====
// State machine that polls flash status and runs the erase and write sequences for the host
`timescale 1ns/1ps

module flashSequencer
  import flashCtrlPkg::*;
(
  input  logic                  Clock,
  input  logic                  arstN,
  input  logic                  FlashOpUnlock,        // Host unlock level
  input  logic                  FlashOpWr,            // Host write request level
  input  logic                  FlashOpEr,            // Host erase request level
  output logic                  FlashCmdAck,          // One-cycle accept pulse
  output logic                  FlashBusy,            // Operation in progress
  output logic                  FlashError,           // Sticky failure flag
  input  logic [flashAddrW-1:0] flashWrAddr,          // Current word address from the cursor
  input  logic [flashDataW-1:0] ramRdData,            // Current word from the holding RAM
  input  logic [ramAddrW-1:0]   wordsLeft,            // Remaining word count
  output logic                  writePrep,            // Load the cursor
  output logic                  writeDone,            // Step the cursor
  output logic                  csrAddr,              // 0 status, 1 control
  output logic                  csrRead,
  output logic [flashDataW-1:0] csrWriteData,
  output logic                  csrWrite,
  input  logic [flashDataW-1:0] csrReadData,          // Status, one cycle after the read
  output logic [flashAddrW-1:0] dataAddr,
  output logic [flashDataW-1:0] dataWriteData,
  output logic                  dataWrite,
  input  logic                  dataWaitReq           // High then low marks a finished write
);

  seqState               state, stateNext;
  logic                  statusIdle;                  // Captured busy field is zero
  logic                  statusWriteOk;               // Captured write-success bit
  logic                  statusEraseOk;               // Captured erase-success bit
  logic                  storeStatus;                 // Read data is valid for capture
  logic                  cmdAckNext;
  logic                  busyClr;                     // Back in the monitor loop
  logic                  errorSet;                    // A success check failed
  logic                  csrAddrNext;
  logic                  csrReadNext;
  logic [flashDataW-1:0] csrWriteDataNext;
  logic                  csrWriteNext;
  logic [flashAddrW-1:0] dataAddrNext;
  logic [flashDataW-1:0] dataWriteDataNext;
  logic                  dataWriteNext;

  // Capture status only where the read pipeline has filled
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      statusIdle    <= 1'b0;
      statusWriteOk <= 1'b0;
      statusEraseOk <= 1'b0;
    end
    else if (storeStatus)
    begin
      statusIdle    <= (csrReadData[statusBusyLsb +: 2] == 2'b00);
      statusWriteOk <= csrReadData[statusWriteOkBit];
      statusEraseOk <= csrReadData[statusEraseOkBit];
    end
  end

  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
      state <= monSet;
    else
      state <= stateNext;
  end

  ////////////////////
  // Next state
  ////////////////////
  always_comb
  begin
    stateNext = state;                                // Wait states hold by default
    case (state)
      monSet      : stateNext = monLat;
      monLat      : stateNext = monStr;
      monStr      : stateNext = monVal;
      monVal      :
        if (statusIdle && FlashOpUnlock && FlashOpWr)
          stateNext = wrPrep;                         // Write wins over erase
        else if (statusIdle && FlashOpUnlock && FlashOpEr)
          stateNext = erPrep;
      erPrep      : stateNext = er1ClrProt;
      er1ClrProt  : stateNext = er1SelErase;
      er1SelErase : stateNext = er1BusySet;
      er1BusySet  : stateNext = er1BusyLat;
      er1BusyLat  : stateNext = er1BusyStr;
      er1BusyStr  : stateNext = er1WaitBusy;
      er1WaitBusy : if (!statusIdle) stateNext = er1WaitIdle;   // Erase has started
      er1WaitIdle : if (statusIdle) stateNext = er1Check;       // Erase has finished
      er1Check    : stateNext = er1Protect;
      er1Protect  : stateNext = er2ClrProt;
      er2ClrProt  : stateNext = er2SelErase;
      er2SelErase : stateNext = er2BusySet;
      er2BusySet  : stateNext = er2BusyLat;
      er2BusyLat  : stateNext = er2BusyStr;
      er2BusyStr  : stateNext = er2WaitBusy;
      er2WaitBusy : if (!statusIdle) stateNext = er2WaitIdle;
      er2WaitIdle : if (statusIdle) stateNext = er2Check;
      er2Check    : stateNext = er2Protect;
      er2Protect  : stateNext = monSet;
      wrPrep      : stateNext = wrUnprot;
      wrUnprot    : stateNext = wrLoad;
      wrLoad      : stateNext = wrCommit;             // RAM output settles here
      wrCommit    : stateNext = wrReqHigh;
      wrReqHigh   : if (dataWaitReq) stateNext = wrReqLow;  // Flash took the write
      wrReqLow    : if (!dataWaitReq) stateNext = wrIdleSet;
      wrIdleSet   : stateNext = wrIdleStr;
      wrIdleStr   : stateNext = wrWaitIdle;
      wrWaitIdle  : if (statusIdle) stateNext = wrCheck;
      wrCheck     :
        if (wordsLeft > ramAddrW'(1))
          stateNext = wrLoad;                         // More words to go
        else
          stateNext = wrProtect;
      wrProtect   : stateNext = monSet;
      default     : stateNext = monSet;
    endcase
  end

  ////////////////////
  // State decode
  ////////////////////
  always_comb
  begin
    csrAddrNext       = 1'b0;
    csrReadNext       = 1'b0;
    csrWriteNext      = 1'b0;
    dataAddrNext      = '0;
    dataWriteDataNext = '0;
    dataWriteNext     = 1'b0;
    storeStatus       = 1'b0;
    cmdAckNext        = 1'b0;
    busyClr           = 1'b0;
    errorSet          = 1'b0;
    writePrep         = 1'b0;
    writeDone         = 1'b0;
    case (state)
      monSet, monLat, er1BusySet, er1BusyLat, er2BusySet, er2BusyLat :
        csrReadNext = 1'b1;                           // Start status reads
      monStr, er1BusyStr, er1WaitBusy, er1WaitIdle, er2BusyStr, er2WaitBusy,
      er2WaitIdle, wrIdleSet, wrIdleStr, wrWaitIdle :
      begin
        csrReadNext = 1'b1;
        storeStatus = 1'b1;                           // Earlier read now returning
      end
      monVal :
      begin
        csrReadNext = 1'b1;
        storeStatus = 1'b1;
        busyClr     = 1'b1;                           // Ready for the next command
      end
      erPrep :
        cmdAckNext = 1'b1;
      er1ClrProt, er1SelErase, er1Protect, er2ClrProt, er2SelErase, er2Protect,
      wrUnprot, wrProtect :
      begin
        csrAddrNext  = 1'b1;                          // Control register
        csrWriteNext = 1'b1;
      end
      er1Check, er2Check :
        errorSet = !statusEraseOk;
      wrPrep :
      begin
        cmdAckNext = 1'b1;
        writePrep  = 1'b1;                            // Cursor to the first word
      end
      wrLoad :
      begin
        dataAddrNext      = flashWrAddr;              // Address and data ahead of the strobe
        dataWriteDataNext = ramRdData;
      end
      wrCommit, wrReqHigh, wrReqLow :
      begin
        dataAddrNext      = flashWrAddr;
        dataWriteDataNext = ramRdData;
        dataWriteNext     = (state != wrReqLow) || dataWaitReq;  // Hold until the write lands
        csrReadNext       = 1'b1;                     // Keep the read pipeline full
      end
      wrCheck :
      begin
        errorSet  = !statusWriteOk;
        writeDone = 1'b1;                             // Step to the next word
      end
      default :
        csrReadNext = 1'b0;
    endcase
  end

  // CSR word for each control write
  always_comb
  begin
    case (state)
      er1ClrProt  : csrWriteDataNext = csrUnprotCfm1;
      er1SelErase : csrWriteDataNext = csrEraseCfm1;
      er2ClrProt  : csrWriteDataNext = csrUnprotCfm2;
      er2SelErase : csrWriteDataNext = csrEraseCfm2;
      wrUnprot    : csrWriteDataNext = csrUnprotBoth;
      er1Protect, er2Protect, wrProtect :
        csrWriteDataNext = csrProtectNone;            // Restore protection
      default     : csrWriteDataNext = '0;
    endcase
  end

  ////////////////////
  // Registered outputs
  ////////////////////
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      csrAddr   <= 1'b0;
      csrRead   <= 1'b0;
      csrWrite  <= 1'b0;
      dataWrite <= 1'b0;
    end
    else
    begin
      csrAddr   <= csrAddrNext;
      csrRead   <= csrReadNext;
      csrWrite  <= csrWriteNext;
      dataWrite <= dataWriteNext;
    end
  end

  // Bus payload, qualified by the strobes above
  always_ff @(posedge Clock)
  begin
    csrWriteData  <= csrWriteDataNext;
    dataAddr      <= dataAddrNext;
    dataWriteData <= dataWriteDataNext;
  end

  // Host flags
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      FlashCmdAck <= 1'b0;
      FlashBusy   <= 1'b0;
      FlashError  <= 1'b0;
    end
    else
    begin
      FlashCmdAck <= cmdAckNext;
      if (cmdAckNext)
        FlashBusy <= 1'b1;                            // Rises with the ack
      else if (busyClr)
        FlashBusy <= 1'b0;
      if (cmdAckNext)
        FlashError <= 1'b0;                           // Each command starts clean
      else if (errorSet)
        FlashError <= 1'b1;
    end
  end

endmodule

// ==== flashUpdateCtrl.sv ====
// Top level of the flash update controller; connects host and flash ports to the datapath
`timescale 1ns/1ps

module flashUpdateCtrl
  import flashCtrlPkg::*;
(
  input  logic                  Clock,
  input  logic                  arstN,
  // Host side
  input  logic [hostAddrW-1:0]  FlashMemWrAddress,
  input  logic [hostDataW-1:0]  FlashMemWrData,
  input  logic                  FlashMemWrEn,
  input  logic [flashAddrW-1:0] FlashOpAddr,
  input  logic [ramAddrW-1:0]   FlashOpLen,
  input  logic                  FlashOpUnlock,
  input  logic                  FlashOpWr,
  input  logic                  FlashOpEr,
  output logic                  FlashCmdAck,
  output logic                  FlashBusy,
  output logic                  FlashError,
  // Flash CSR port
  output logic                  csrAddr,
  output logic                  csrRead,
  output logic [flashDataW-1:0] csrWriteData,
  output logic                  csrWrite,
  input  logic [flashDataW-1:0] csrReadData,
  // Flash data port
  output logic [flashAddrW-1:0] dataAddr,
  output logic [flashDataW-1:0] dataWriteData,
  output logic                  dataWrite,
  input  logic                  dataWaitReq
);

  logic [ramAddrW-1:0]   ramRdAddr;                   // Cursor to RAM
  logic [flashDataW-1:0] ramRdData;                   // RAM to sequencer
  logic [flashAddrW-1:0] flashWrAddr;                 // Cursor to sequencer
  logic [ramAddrW-1:0]   wordsLeft;
  logic                  writePrep;                   // Sequencer to cursor
  logic                  writeDone;

  flashStageRam flashStageRam_i (
    .Clock             (Clock),
    .arstN             (arstN),
    .FlashMemWrAddress (FlashMemWrAddress),
    .FlashMemWrData    (FlashMemWrData),
    .FlashMemWrEn      (FlashMemWrEn),
    .ramRdAddr         (ramRdAddr),
    .ramRdData         (ramRdData)
  );

  flashWriteCursor flashWriteCursor_i (
    .Clock       (Clock),
    .arstN       (arstN),
    .writePrep   (writePrep),
    .writeDone   (writeDone),
    .FlashOpAddr (FlashOpAddr),
    .FlashOpLen  (FlashOpLen),
    .ramRdAddr   (ramRdAddr),
    .flashWrAddr (flashWrAddr),
    .wordsLeft   (wordsLeft)
  );

  flashSequencer flashSequencer_i (
    .Clock         (Clock),
    .arstN         (arstN),
    .FlashOpUnlock (FlashOpUnlock),
    .FlashOpWr     (FlashOpWr),
    .FlashOpEr     (FlashOpEr),
    .FlashCmdAck   (FlashCmdAck),
    .FlashBusy     (FlashBusy),
    .FlashError    (FlashError),
    .flashWrAddr   (flashWrAddr),
    .ramRdData     (ramRdData),
    .wordsLeft     (wordsLeft),
    .writePrep     (writePrep),
    .writeDone     (writeDone),
    .csrAddr       (csrAddr),
    .csrRead       (csrRead),
    .csrWriteData  (csrWriteData),
    .csrWrite      (csrWrite),
    .csrReadData   (csrReadData),
    .dataAddr      (dataAddr),
    .dataWriteData (dataWriteData),
    .dataWrite     (dataWrite),
    .dataWaitReq   (dataWaitReq)
  );

endmodule

// ==== flashModel.sv ====
// Behavioral flash for the testbench; serves CSR status and protect, data writes and erases
`timescale 1ns/1ps

module flashModel
  import flashCtrlPkg::*;
(
  input  logic                  Clock,
  input  logic                  arstN,
  input  logic                  failNext,             // Fail every write or erase while high
  input  logic                  csrAddr,
  input  logic                  csrRead,
  input  logic [flashDataW-1:0] csrWriteData,
  input  logic                  csrWrite,
  output logic [flashDataW-1:0] csrReadData,
  input  logic [flashAddrW-1:0] dataAddr,
  input  logic [flashDataW-1:0] dataWriteData,
  input  logic                  dataWrite,
  output logic                  dataWaitReq
);

  localparam int memWords    = 1024;                  // CFM1 low half, CFM2 high half
  localparam int cfm1ProtBit = 26;                    // Protect bit of CFM1
  localparam int cfm2ProtBit = 25;                    // Protect bit of CFM2

  logic [flashDataW-1:0] mem [0:memWords-1];
  logic [flashDataW-1:0] protWord;                    // Latest control word
  logic [flashDataW-1:0] status;
  logic                  writeOk;
  logic                  eraseOk;
  logic                  erase1;
  logic                  erase2;
  logic                  eraseGood;
  logic                  writeGood;
  logic [1:0]            wrPhase;                     // 0 idle, 1 stalling, 2 releasing
  int                    busyCnt;                     // Cycles left in the busy state
  int                    stallCnt;
  int                    seed;

  // Address-dependent start contents
  initial
  begin
    seed = 72;
    for (int i = 0; i < memWords; i++)
      mem[i] = 32'h5A00_0000 ^ i;
  end

  always_comb
  begin
    status                         = '0;
    status[statusBusyLsb +: 2]     = (busyCnt != 0) ? 2'b01 : 2'b00;
    status[statusWriteOkBit]       = writeOk;
    status[statusEraseOkBit]       = eraseOk;
  end

  // Sector select field sits in bits 22:20
  assign erase1    = csrWrite && csrAddr && (csrWriteData[22:20] == csrEraseCfm1[22:20]);
  assign erase2    = csrWrite && csrAddr && (csrWriteData[22:20] == csrEraseCfm2[22:20]);
  assign eraseGood = !failNext && !csrWriteData[erase1 ? cfm1ProtBit : cfm2ProtBit];
  assign writeGood = !failNext && !protWord[cfm1ProtBit] && !protWord[cfm2ProtBit];

  always @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      csrReadData <= '0;
      dataWaitReq <= 1'b0;
      protWord    <= csrProtectNone;
      writeOk     <= 1'b0;
      eraseOk     <= 1'b0;
      wrPhase     <= 2'd0;
      busyCnt     <= 0;
      stallCnt    <= 0;
    end
    else
    begin
      if (busyCnt != 0)
        busyCnt <= busyCnt - 1;
      if (csrRead && !csrAddr)
        csrReadData <= status;                        // Status one cycle after the read
      if (csrWrite && csrAddr)
        protWord <= csrWriteData;
      if (erase1 || erase2)
      begin
        eraseOk <= eraseGood;
        busyCnt <= 4 + ($random(seed) & 7);           // Long enough to be seen busy
        if (eraseGood)
          for (int i = 0; i < memWords / 2; i++)
            mem[(erase2 ? memWords / 2 : 0) + i] <= '1;
      end
      case (wrPhase)
        2'd0 :
          if (dataWrite)
          begin
            writeOk     <= writeGood;
            if (writeGood)
              mem[dataAddr[9:0]] <= dataWriteData;
            busyCnt     <= 2 + ($random(seed) & 7);
            stallCnt    <= $random(seed) & 3;
            dataWaitReq <= 1'b1;                      // Stall the write
            wrPhase     <= 2'd1;
          end
        2'd1 :
          if (stallCnt == 0)
          begin
            dataWaitReq <= 1'b0;
            wrPhase     <= 2'd2;
          end
          else
            stallCnt <= stallCnt - 1;
        default :
          wrPhase <= 2'd0;                            // Strobe drops this cycle
      endcase
    end
  end

endmodule

// ==== flashUpdateCtrlTb.sv ====
// Testbench for the flash update controller; runs write, erase and error cases on a flash model
`timescale 1ns/1ps

module flashUpdateCtrlTb import flashCtrlPkg::*; ();

  logic                  Clock, arstN, failNext;
  logic [hostAddrW-1:0]  FlashMemWrAddress;
  logic [hostDataW-1:0]  FlashMemWrData;
  logic                  FlashMemWrEn;
  logic [flashAddrW-1:0] FlashOpAddr, dataAddr;
  logic [ramAddrW-1:0]   FlashOpLen;
  logic                  FlashOpUnlock, FlashOpWr, FlashOpEr;
  logic                  FlashCmdAck, FlashBusy, FlashError;
  logic                  csrAddr, csrRead, csrWrite, dataWrite, dataWaitReq;
  logic [flashDataW-1:0] csrWriteData, csrReadData, dataWriteData;

  int                    seed;
  int                    mismatchCount;               // Checks in the stimulus process
  int                    otherCount;
  int                    protErrors;                  // Checks in the bus monitor
  int                    busErrors;
  int                    ackCount;
  bit                    cmdIssued;                   // An unlocked command was driven
  logic [flashDataW-1:0] lastCsr;
  logic [flashDataW-1:0] csrLog [$];                  // Every control word seen
  logic [hostDataW-1:0]  hostWords [0:127];
  logic [flashDataW-1:0] expMem [0:1023];             // Expected flash contents

  flashUpdateCtrl flashUpdateCtrl_i (.*);
  flashModel      flashModel_i (.*);

  always #10 Clock = ~Clock;

  ////////////////////
  // Bus monitor
  ////////////////////
  always @(posedge Clock)
  begin
    if (FlashCmdAck)
      ackCount++;
    if (csrWrite || dataWrite)
      assert (cmdIssued)                              // No flash traffic before a command
      else
      begin
        $display("Flash bus activity at %0t before any accepted command", $time);
        busErrors++;
      end
    if (dataWrite)
      assert (lastCsr == csrUnprotBoth)               // Both sectors open for data
      else
      begin
        $display("MISMATCH at %0t: data write under control word %h", $time, lastCsr);
        protErrors++;
      end
    if (csrWrite && csrAddr)
    begin
      lastCsr = csrWriteData;
      csrLog.push_back(csrWriteData);
    end
  end

  task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
    else
    begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      mismatchCount++;
    end
  endtask

  task automatic compareMem();
    for (int i = 0; i < 1024; i++)
      checkVal(flashModel_i.mem[i], expMem[i], $sformatf("flash word %0d", i));
  endtask

  // Host words fill the RAM from entry 0 with the even address first
  task automatic loadWords(input int n);
    for (int i = 0; i < 2 * n; i++)
    begin
      hostWords[i] = hostDataW'($random(seed));
      @(posedge Clock);
      FlashMemWrAddress <= hostAddrW'(i);
      FlashMemWrData    <= hostWords[i];
      FlashMemWrEn      <= 1'b1;
    end
    @(posedge Clock);
    FlashMemWrEn <= 1'b0;
  endtask

  task automatic runCmd(input bit wr, input int addr, input int len, input bit expErr);
    int waitCnt;
    int acksBefore;
    cmdIssued  = 1'b1;
    acksBefore = ackCount;
    waitCnt    = 0;
    @(posedge Clock);
    FlashOpAddr   <= flashAddrW'(addr);
    FlashOpLen    <= ramAddrW'(len);
    FlashOpUnlock <= 1'b1;
    FlashOpWr     <= wr;
    FlashOpEr     <= !wr;
    do
    begin
      @(posedge Clock);
      waitCnt++;
    end
    while (!FlashCmdAck && waitCnt < 100);
    FlashOpUnlock <= 1'b0;                            // Host lets go on the ack
    FlashOpWr     <= 1'b0;
    FlashOpEr     <= 1'b0;
    if (!FlashCmdAck)
    begin
      $display("Timed out at %0t waiting for the command ack", $time);
      otherCount++;
    end
    checkVal(FlashBusy, 1, "busy on ack");
    checkVal(FlashError, 0, "error on ack");
    waitCnt = 0;
    while (FlashBusy && waitCnt < 5000)
    begin
      @(posedge Clock);
      waitCnt++;
    end
    if (FlashBusy)
    begin
      $display("Timed out at %0t waiting for the operation to finish", $time);
      otherCount++;
    end
    checkVal(ackCount - acksBefore, 1, "ack pulses");
    checkVal(FlashError, expErr, "error flag");
    checkVal(lastCsr, csrProtectNone, "final control word");
  endtask

  task automatic writeWords(input int addr, input int len, input bit fail);
    int n;
    int logBase;
    n = (len == 0) ? 1 : len;                         // Zero length still writes one word
    loadWords(n);
    logBase = csrLog.size();
    failNext <= fail;
    runCmd(1'b1, addr, len, fail);
    failNext <= 1'b0;
    if (!fail)
      for (int i = 0; i < n; i++)
        expMem[addr + i] = {hostWords[2 * i], hostWords[2 * i + 1]};
    checkVal(csrLog.size() - logBase, 2, "control writes in a write");
    checkVal(csrLog[logBase], csrUnprotBoth, "unprotect word");
    compareMem();
  endtask

  task automatic eraseSectors(input bit fail);
    logic [flashDataW-1:0] eraseSeq [0:5];
    int logBase;
    eraseSeq = '{csrUnprotCfm1, csrEraseCfm1, csrProtectNone,
                 csrUnprotCfm2, csrEraseCfm2, csrProtectNone};
    logBase  = csrLog.size();
    failNext <= fail;
    runCmd(1'b0, 0, 0, fail);
    failNext <= 1'b0;
    checkVal(csrLog.size() - logBase, 6, "control writes in an erase");
    for (int i = 0; i < 6; i++)
      checkVal(csrLog[logBase + i], eraseSeq[i], $sformatf("erase control word %0d", i));
    if (!fail)
      for (int i = 0; i < 1024; i++)
        expMem[i] = '1;
    compareMem();
  endtask

  // Requests without unlock must leave the controller idle
  task automatic ignoredCmd();
    int acksBefore;
    acksBefore = ackCount;
    @(posedge Clock);
    FlashOpWr <= 1'b1;
    FlashOpEr <= 1'b1;
    repeat (40)
    begin
      @(posedge Clock);
      checkVal(FlashBusy, 0, "busy without unlock");
    end
    FlashOpWr <= 1'b0;
    FlashOpEr <= 1'b0;
    checkVal(ackCount - acksBefore, 0, "acks without unlock");
  endtask

  initial
  begin
    seed              = 72;
    Clock             = 1'b0;
    arstN             = 1'b0;
    failNext          = 1'b0;
    FlashMemWrAddress = '0;
    FlashMemWrData    = '0;
    FlashMemWrEn      = 1'b0;
    FlashOpAddr       = '0;
    FlashOpLen        = '0;
    FlashOpUnlock     = 1'b0;
    FlashOpWr         = 1'b0;
    FlashOpEr         = 1'b0;
    cmdIssued         = 1'b0;
    lastCsr           = '0;
    for (int i = 0; i < 1024; i++)
      expMem[i] = 32'h5A00_0000 ^ i;                  // Same start contents as the model
    repeat (10) @(posedge Clock);
    checkVal(csrRead, 0, "status read in reset");
    arstN <= 1'b1;
    repeat (4) @(posedge Clock);
    checkVal(FlashCmdAck, 0, "ack after reset");
    checkVal(FlashBusy, 0, "busy after reset");
    checkVal(FlashError, 0, "error after reset");
    checkVal(csrRead, 1, "status polling after reset");
    ignoredCmd();
    writeWords(100, 5, 1'b0);
    writeWords(300, 0, 1'b0);
    writeWords(400, 1, 1'b0);
    eraseSectors(1'b0);
    writeWords(700, 3, 1'b1);                         // Injected write failure
    writeWords(520, 4, 1'b0);                         // Clears the error
    writeWords(0, 63, 1'b0);
    eraseSectors(1'b1);
    writeWords(60, 2, 1'b0);
    repeat (5) @(posedge Clock);
    $display("Errors: %0d mismatches, %0d other failures",
             mismatchCount + protErrors, otherCount + busErrors);
    if (mismatchCount + protErrors + otherCount + busErrors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== flashUpdateCtrl.f ====
flashCtrlPkg.sv
flashStageRam.sv
flashWriteCursor.sv
flashSequencer.sv
flashUpdateCtrl.sv
flashModel.sv
flashUpdateCtrlTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert -Wno-fatal
TOP      = flashUpdateCtrlTb
FILELIST = flashUpdateCtrl.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
